// File: Bender.yml
package:
  name: blur

sources:
  - design/blur_pkg.sv
  - design/blur_ctrl.sv
  - design/row_window.sv
  - design/gauss_3x3.sv
  - design/strip_merge.sv
  - design/blur_top.sv
  - target: test
    files:
      - tb/blur_props.sv
      - tb/blur_tb.sv

// File: design/blur_ctrl.sv
`timescale 1ns/1ps

module blur_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic                 row_written,
  output blur_pkg::addr_t      img_addr,
  output blur_pkg::addr_t      blur_addr_r,
  output blur_pkg::addr_t      out_row,
  output blur_pkg::strip_idx_t strip_idx,
  output logic                 row_load,
  output logic                 row_zero,
  output logic                 win_clear,
  output logic                 blur_go,
  output logic                 done
);

  blur_pkg::ctrl_state_t state;
  blur_pkg::ctrl_state_t state_nxt;
  blur_pkg::addr_t       next_row;
  logic                  last_row;
  logic                  last_strip;
  logic                  below_image;

  assign next_row    = out_row + blur_pkg::addr_t'(1);
  assign below_image = (next_row == blur_pkg::addr_t'(blur_pkg::img_rows));
  assign last_row    = (out_row == blur_pkg::addr_t'(blur_pkg::img_rows - 1));
  assign last_strip  = (strip_idx == blur_pkg::strip_idx_t'(blur_pkg::num_strips - 1));

  // clearing fills the window with zero rows, the top one stands for row -1
  assign win_clear = (state == blur_pkg::st_prime);

  // row 0 while priming, then the row below the current output row
  // held on the last row when the zero row is used instead
  always_comb begin
    if (state == blur_pkg::st_prime)
      img_addr = '0;
    else if (below_image)
      img_addr = blur_pkg::addr_t'(blur_pkg::img_rows - 1);
    else
      img_addr = next_row;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      blur_pkg::st_idle:  if (start) state_nxt = blur_pkg::st_prime;
      blur_pkg::st_prime: state_nxt = blur_pkg::st_fetch;
      blur_pkg::st_fetch: state_nxt = blur_pkg::st_blur;
      blur_pkg::st_blur:  state_nxt = blur_pkg::st_write;
      blur_pkg::st_write: begin
        if (row_written) begin
          if (!last_row)
            state_nxt = blur_pkg::st_fetch;
          else if (!last_strip)
            state_nxt = blur_pkg::st_prime;
          else
            state_nxt = blur_pkg::st_idle;
        end
      end
      default: state_nxt = blur_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= blur_pkg::st_idle;
      out_row     <= '0;
      strip_idx   <= '0;
      blur_addr_r <= '0;
      row_load    <= 1'b0;
      row_zero    <= 1'b0;
      blur_go     <= 1'b0;
      done        <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == blur_pkg::st_idle && start) begin
        out_row   <= '0;
        strip_idx <= '0;
      end else if (state == blur_pkg::st_write && row_written) begin
        // strip wraps to 0 after the last one
        out_row <= last_row ? '0 : next_row;
        if (last_row)
          strip_idx <= strip_idx + blur_pkg::strip_idx_t'(1);
      end
      // image data shows up one cycle after the address
      row_load <= (state == blur_pkg::st_prime) ||
                  (state == blur_pkg::st_fetch && !below_image);
      row_zero <= (state == blur_pkg::st_fetch) && below_image;
      // stored row is read alongside blur_go, ready before the result
      if (state == blur_pkg::st_blur)
        blur_addr_r <= out_row;
      blur_go <= (state == blur_pkg::st_blur);
      done    <= (state == blur_pkg::st_write) && row_written && last_row && last_strip;
    end
  end

endmodule

// File: design/blur_pkg.sv
package blur_pkg;

  // image geometry
  localparam int pix_w       = 8;
  localparam int strip_px    = 4;
  localparam int num_strips  = 4;
  localparam int img_rows    = 8;
  localparam int row_px      = strip_px * num_strips;
  localparam int row_w       = row_px * pix_w;
  localparam int strip_w     = strip_px * pix_w;

  // one extra bit so a row address can also hold img_rows
  localparam int addr_w      = 4;
  localparam int strip_idx_w = 2;

  typedef logic [pix_w-1:0]       pix_t;
  typedef logic [row_w-1:0]       row_t;
  typedef logic [strip_w-1:0]     strip_t;
  typedef logic [addr_w-1:0]      addr_t;
  typedef logic [strip_idx_w-1:0] strip_idx_t;

  // strip and row sequencing
  typedef enum logic [2:0] {
    st_idle,
    st_prime,
    st_fetch,
    st_blur,
    st_write
  } ctrl_state_t;

endpackage

// File: design/blur_top.sv
`timescale 1ns/1ps

module blur_top (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  blur_pkg::row_t  img_dout,
  input  blur_pkg::row_t  blur_dout,
  output logic            done,
  output blur_pkg::addr_t img_addr,
  output blur_pkg::addr_t blur_addr_r,
  output logic            blur_we,
  output blur_pkg::addr_t blur_addr_w,
  output blur_pkg::row_t  blur_din
);

  blur_pkg::addr_t                         out_row;
  blur_pkg::strip_idx_t                    strip_idx;
  logic                                    row_load;
  logic                                    row_zero;
  logic                                    win_clear;
  logic                                    blur_go;
  logic                                    row_written;
  blur_pkg::pix_t [blur_pkg::strip_px+1:0] win_top;
  blur_pkg::pix_t [blur_pkg::strip_px+1:0] win_mid;
  blur_pkg::pix_t [blur_pkg::strip_px+1:0] win_bot;
  logic                                    res_valid;
  blur_pkg::strip_t                        res_strip;

  blur_ctrl i_blur_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .row_written (row_written),
    .img_addr    (img_addr),
    .blur_addr_r (blur_addr_r),
    .out_row     (out_row),
    .strip_idx   (strip_idx),
    .row_load    (row_load),
    .row_zero    (row_zero),
    .win_clear   (win_clear),
    .blur_go     (blur_go),
    .done        (done)
  );

  row_window i_row_window (
    .clk       (clk),
    .rst_n     (rst_n),
    .img_dout  (img_dout),
    .row_load  (row_load),
    .row_zero  (row_zero),
    .win_clear (win_clear),
    .strip_idx (strip_idx),
    .win_top   (win_top),
    .win_mid   (win_mid),
    .win_bot   (win_bot)
  );

  gauss_3x3 i_gauss_3x3 (
    .clk       (clk),
    .rst_n     (rst_n),
    .blur_go   (blur_go),
    .win_top   (win_top),
    .win_mid   (win_mid),
    .win_bot   (win_bot),
    .res_valid (res_valid),
    .res_strip (res_strip)
  );

  strip_merge i_strip_merge (
    .clk         (clk),
    .rst_n       (rst_n),
    .res_valid   (res_valid),
    .res_strip   (res_strip),
    .strip_idx   (strip_idx),
    .out_row     (out_row),
    .blur_dout   (blur_dout),
    .blur_we     (blur_we),
    .blur_addr_w (blur_addr_w),
    .blur_din    (blur_din),
    .row_written (row_written)
  );

endmodule

// File: design/gauss_3x3.sv
`timescale 1ns/1ps

module gauss_3x3 (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     blur_go,
  input  blur_pkg::pix_t [blur_pkg::strip_px+1:0] win_top,
  input  blur_pkg::pix_t [blur_pkg::strip_px+1:0] win_mid,
  input  blur_pkg::pix_t [blur_pkg::strip_px+1:0] win_bot,
  output logic                                     res_valid,
  output blur_pkg::strip_t                         res_strip
);

  // column sums reach 4*255, full kernel sum 16*255 plus rounding
  logic [blur_pkg::strip_px+1:0][blur_pkg::pix_w+1:0] vsum_q;
  logic [blur_pkg::strip_px-1:0][blur_pkg::pix_w+3:0] hsum;
  logic                                                vsum_valid;

  // stage one, vertical 1-2-1 per window column
  always_ff @(posedge clk) begin
    if (blur_go) begin
      for (int i = 0; i < blur_pkg::strip_px + 2; i++) begin
        vsum_q[i] <= {2'b00, win_top[i]} + {1'b0, win_mid[i], 1'b0} + {2'b00, win_bot[i]};
      end
    end
  end

  // horizontal 1-2-1 over neighbouring columns, +8 rounds the divide by 16
  always_comb begin
    for (int j = 0; j < blur_pkg::strip_px; j++) begin
      hsum[j] = {2'b00, vsum_q[j]} + {1'b0, vsum_q[j+1], 1'b0} + {2'b00, vsum_q[j+2]} +
                (blur_pkg::pix_w + 4)'(8);
    end
  end

  // stage two
  always_ff @(posedge clk) begin
    if (vsum_valid) begin
      for (int j = 0; j < blur_pkg::strip_px; j++) begin
        res_strip[j*blur_pkg::pix_w +: blur_pkg::pix_w] <= hsum[j][blur_pkg::pix_w+3:4];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vsum_valid <= 1'b0;
      res_valid  <= 1'b0;
    end else begin
      vsum_valid <= blur_go;
      res_valid  <= vsum_valid;
    end
  end

endmodule

// File: design/row_window.sv
`timescale 1ns/1ps

module row_window (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  blur_pkg::row_t                           img_dout,
  input  logic                                     row_load,
  input  logic                                     row_zero,
  input  logic                                     win_clear,
  input  blur_pkg::strip_idx_t                     strip_idx,
  output blur_pkg::pix_t [blur_pkg::strip_px+1:0] win_top,
  output blur_pkg::pix_t [blur_pkg::strip_px+1:0] win_mid,
  output blur_pkg::pix_t [blur_pkg::strip_px+1:0] win_bot
);

  blur_pkg::row_t row_top;
  blur_pkg::row_t row_mid;
  blur_pkg::row_t row_bot;

  // pixel p of a row, zero outside the image width
  function automatic blur_pkg::pix_t pixel_at(input blur_pkg::row_t row, input int p);
    if (p < 0 || p >= blur_pkg::row_px)
      return '0;
    return row[p*blur_pkg::pix_w +: blur_pkg::pix_w];
  endfunction

  // rows move up, new row enters at the bottom
  always_ff @(posedge clk) begin
    if (!rst_n || win_clear) begin
      row_top <= '0;
      row_mid <= '0;
      row_bot <= '0;
    end else if (row_load || row_zero) begin
      row_top <= row_mid;
      row_mid <= row_bot;
      row_bot <= row_zero ? '0 : img_dout;
    end
  end

  // strip pixels plus one neighbour each side, window pixel 0 is the left one
  always_comb begin
    int base;
    base = int'(strip_idx) * blur_pkg::strip_px - 1;
    for (int i = 0; i < blur_pkg::strip_px + 2; i++) begin
      win_top[i] = pixel_at(row_top, base + i);
      win_mid[i] = pixel_at(row_mid, base + i);
      win_bot[i] = pixel_at(row_bot, base + i);
    end
  end

endmodule

// File: design/strip_merge.sv
`timescale 1ns/1ps

module strip_merge (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 res_valid,
  input  blur_pkg::strip_t     res_strip,
  input  blur_pkg::strip_idx_t strip_idx,
  input  blur_pkg::addr_t      out_row,
  input  blur_pkg::row_t       blur_dout,
  output logic                 blur_we,
  output blur_pkg::addr_t      blur_addr_w,
  output blur_pkg::row_t       blur_din,
  output logic                 row_written
);

  blur_pkg::row_t merged;

  // keep strips to the left, drop in the new one, clear the rest
  always_comb begin
    for (int s = 0; s < blur_pkg::num_strips; s++) begin
      if (s < int'(strip_idx))
        merged[s*blur_pkg::strip_w +: blur_pkg::strip_w] =
          blur_dout[s*blur_pkg::strip_w +: blur_pkg::strip_w];
      else if (s == int'(strip_idx))
        merged[s*blur_pkg::strip_w +: blur_pkg::strip_w] = res_strip;
      else
        merged[s*blur_pkg::strip_w +: blur_pkg::strip_w] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid) begin
      blur_din    <= merged;
      blur_addr_w <= out_row;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      blur_we <= 1'b0;
    else
      blur_we <= res_valid;
  end

  // the write lands on this edge, so the row is done
  assign row_written = blur_we;

endmodule

// File: flist.f
design/blur_pkg.sv
design/blur_ctrl.sv
design/row_window.sv
design/gauss_3x3.sv
design/strip_merge.sv
design/blur_top.sv
tb/blur_props.sv
tb/blur_tb.sv

// File: tb/blur_props.sv
`timescale 1ns/1ps

module blur_props (
  input logic            clk,
  input logic            rst_n,
  input logic            done,
  input logic            blur_we,
  input blur_pkg::addr_t blur_addr_w
);

  int fails = 0;

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      $error("done held high for two cycles");
      fails++;
    end

  // the last write lands before done
  no_write_at_done: assert property (@(posedge clk) disable iff (!rst_n) done |-> !blur_we)
    else begin
      $error("blur_we high while done is high");
      fails++;
    end

  write_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      blur_we |-> blur_addr_w < blur_pkg::addr_t'(blur_pkg::img_rows))
    else begin
      $error("blur write address past the last row");
      fails++;
    end

endmodule

bind blur_top blur_props i_blur_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .done        (done),
  .blur_we     (blur_we),
  .blur_addr_w (blur_addr_w)
);

// File: tb/blur_tb.sv
`timescale 1ns/1ps

module blur_tb;

  localparam int timeout_cycles = 2000;

  logic            clk = 1'b0;
  logic            rst_n = 1'b0;
  logic            start = 1'b0;
  blur_pkg::row_t  img_dout = '0;
  blur_pkg::row_t  blur_dout = '0;
  logic            done;
  blur_pkg::addr_t img_addr;
  blur_pkg::addr_t blur_addr_r;
  logic            blur_we;
  blur_pkg::addr_t blur_addr_w;
  blur_pkg::row_t  blur_din;

  blur_pkg::row_t  img_mem [blur_pkg::img_rows];
  blur_pkg::row_t  blur_mem [blur_pkg::img_rows];
  blur_pkg::row_t  exp_rows [blur_pkg::img_rows];
  blur_pkg::addr_t wr_addr_q [$];
  blur_pkg::row_t  wr_data_q [$];
  logic [31:0]     lfsr = 32'hb15872b3;
  int              done_count = 0;
  int              errors = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  int              test_errors;
  string           test_name;

  blur_top i_blur_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .img_dout    (img_dout),
    .blur_dout   (blur_dout),
    .done        (done),
    .img_addr    (img_addr),
    .blur_addr_r (blur_addr_r),
    .blur_we     (blur_we),
    .blur_addr_w (blur_addr_w),
    .blur_din    (blur_din)
  );

  always #50 clk = ~clk;

  // both SRAMs answer one cycle after the address
  always @(posedge clk) begin
    img_dout  <= img_mem[img_addr];
    blur_dout <= blur_mem[blur_addr_r];
    if (blur_we)
      blur_mem[blur_addr_w] <= blur_din;
  end

  // record done pulses and blur writes
  always @(negedge clk) begin
    if (rst_n && done)
      done_count++;
    if (rst_n && blur_we) begin
      wr_addr_q.push_back(blur_addr_w);
      wr_data_q.push_back(blur_din);
    end
  end

  // taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_row(output blur_pkg::row_t row);
    for (int b = 0; b < blur_pkg::row_w; b++) begin
      lfsr = lfsr_step(lfsr);
      row[b] = lfsr[0];
    end
  endtask

  // zero outside the image
  function automatic int pixel(input int r, input int c);
    if (r < 0 || r >= blur_pkg::img_rows || c < 0 || c >= blur_pkg::row_px)
      return 0;
    return int'(img_mem[r][c*blur_pkg::pix_w +: blur_pkg::pix_w]);
  endfunction

  // binomial weights with a rounded divide by 16
  task automatic compute_expected();
    int sum;
    for (int r = 0; r < blur_pkg::img_rows; r++)
      for (int c = 0; c < blur_pkg::row_px; c++) begin
        sum = 8;
        for (int dr = -1; dr <= 1; dr++)
          for (int dc = -1; dc <= 1; dc++)
            sum += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * pixel(r + dr, c + dc);
        exp_rows[r][c*blur_pkg::pix_w +: blur_pkg::pix_w] = blur_pkg::pix_t'(sum >> 4);
      end
  endtask

  task automatic load_image();
    for (int r = 0; r < blur_pkg::img_rows; r++)
      random_row(img_mem[r]);
    compute_expected();
  endtask

  task automatic fill_blur(input logic random_fill);
    for (int r = 0; r < blur_pkg::img_rows; r++) begin
      if (random_fill)
        random_row(blur_mem[r]);
      else
        blur_mem[r] = '0;
    end
  endtask

  task automatic clear_monitors();
    wr_addr_q.delete();
    wr_data_q.delete();
    done_count = 0;
  endtask

  task automatic compare_row(input string what, input blur_pkg::row_t exp,
                             input blur_pkg::row_t act);
    if (act !== exp) begin
      $display("error %s %s expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic compare_addr(input string what, input blur_pkg::addr_t exp,
                              input blur_pkg::addr_t act);
    if (act !== exp) begin
      $display("error %s %s expected %0d actual %0d", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s %s expected %b actual %b", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic compare_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("error %s %s expected %0d actual %0d", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
    clear_monitors();
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_errors) begin
      $display("test %s ok", test_name);
    end else begin
      $display("test %s failed with %0d errors", test_name, errors - test_errors);
      tests_failed++;
    end
  endtask

  task automatic finish_run();
    if (i_blur_top.i_blur_props.fails != 0) begin
      $display("bound assertions failed %0d times", i_blur_top.i_blur_props.fails);
      errors += i_blur_top.i_blur_props.fails;
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  endtask

  // starts on a falling edge and returns once the done pulse is over
  task automatic run_blur();
    int cycles;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    cycles = 0;
    while (!done && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout in test %s, done never came after start", test_name);
      errors++;
      end_test();
      finish_run();
    end else begin
      cycles = 0;
      while (done && cycles < timeout_cycles) begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic check_rows();
    for (int r = 0; r < blur_pkg::img_rows; r++)
      compare_row($sformatf("row %0d", r), exp_rows[r], blur_mem[r]);
  endtask

  // writes come strip by strip with rows in order
  task automatic check_strip_writes();
    blur_pkg::row_t exp;
    int             s;
    int             r;
    compare_count("write count", blur_pkg::num_strips * blur_pkg::img_rows, wr_data_q.size());
    for (int k = 0; k < wr_data_q.size() && k < blur_pkg::num_strips * blur_pkg::img_rows;
         k++) begin
      s   = k / blur_pkg::img_rows;
      r   = k % blur_pkg::img_rows;
      exp = '0;
      for (int t = 0; t <= s; t++)
        exp[t*blur_pkg::strip_w +: blur_pkg::strip_w] =
          exp_rows[r][t*blur_pkg::strip_w +: blur_pkg::strip_w];
      compare_addr($sformatf("write %0d address", k), blur_pkg::addr_t'(r), wr_addr_q[k]);
      compare_row($sformatf("write %0d strip %0d", k, s), exp, wr_data_q[k]);
    end
  endtask

  initial begin
    fill_blur(1'b0);
    for (int r = 0; r < blur_pkg::img_rows; r++)
      img_mem[r] = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset");
    repeat (10) begin
      @(negedge clk);
      compare_bit("done", 1'b0, done);
      compare_bit("blur_we", 1'b0, blur_we);
    end
    end_test();

    begin_test("zero_prefill");
    fill_blur(1'b0);
    load_image();
    run_blur();
    check_rows();
    repeat (3) @(negedge clk);
    compare_count("done pulses", 1, done_count);
    end_test();

    begin_test("random_prefill");
    fill_blur(1'b1);
    load_image();
    run_blur();
    check_rows();
    end_test();

    begin_test("strip_writes");
    fill_blur(1'b1);
    load_image();
    run_blur();
    check_strip_writes();
    end_test();

    // second start follows right after the first done pulse
    begin_test("back_to_back");
    fill_blur(1'b1);
    load_image();
    run_blur();
    check_rows();
    load_image();
    run_blur();
    check_rows();
    repeat (3) @(negedge clk);
    compare_count("done pulses", 2, done_count);
    end_test();

    finish_run();
  end

endmodule
